/* vc_port_ctrl.f */
+incdir+include
source/noc_pkg.sv
source/rr_arbiter.sv
source/ovc_status.sv
source/ivc_assign_table.sv
source/vc_port_ctrl.sv
dv/vc_port_ctrl_chk.sv
dv/vc_port_ctrl_tb.sv

/* Bender.yml */
package:
  name: vc_port_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/noc_pkg.sv
      - source/rr_arbiter.sv
      - source/ovc_status.sv
      - source/ivc_assign_table.sv
      - source/vc_port_ctrl.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/vc_port_ctrl_chk.sv
      - dv/vc_port_ctrl_tb.sv

/* dv/vc_port_ctrl_tb.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

module vc_port_ctrl_tb;

    // one cycle of inputs for one port
    typedef struct packed {
        noc_pkg::ivc_alloc_t alloc;
        noc_pkg::vc_mask_t   wr;
        noc_pkg::vc_mask_t   credit;
        logic                cand_en;
    } port_stim_t;

    // outputs expected for one port after the sampling edge
    typedef struct packed {
        noc_pkg::ivc_state_t state;
        noc_pkg::vc_mask_t   credit;
        noc_pkg::ovc_flags_t flags;
        noc_pkg::vc_mask_t   cand;
    } port_exp_t;

    typedef struct packed {
        port_stim_t [`PORT_NUM-1:0] stim;
        port_exp_t  [`PORT_NUM-1:0] expv;
    } row_t;

    logic clk;
    logic reset;

    noc_pkg::ivc_alloc_t [`PORT_NUM-1:0] alloc_in;
    noc_pkg::ivc_state_t [`PORT_NUM-1:0] ivc_state;
    noc_pkg::vc_mask_t   [`PORT_NUM-1:0] credit_out;
    noc_pkg::vc_mask_t   [`PORT_NUM-1:0] ovc_wr;
    noc_pkg::vc_mask_t   [`PORT_NUM-1:0] credit_in;
    logic                [`PORT_NUM-1:0] cand_en;
    noc_pkg::ovc_flags_t [`PORT_NUM-1:0] ovc_flags;
    noc_pkg::vc_mask_t   [`PORT_NUM-1:0] cand_vc;

    row_t  rows[$];
    string names[$];

    // row under construction
    // expectations carry over between rows
    port_stim_t [`PORT_NUM-1:0] st;
    port_exp_t  [`PORT_NUM-1:0] ex;

    int unsigned cycles = 0;
    int unsigned cycle_limit;

    vc_port_ctrl dut0 (
        .clk        (clk),
        .reset      (reset),
        .alloc_in   (alloc_in),
        .ivc_state  (ivc_state),
        .credit_out (credit_out),
        .ovc_wr     (ovc_wr),
        .credit_in  (credit_in),
        .cand_en    (cand_en),
        .ovc_flags  (ovc_flags),
        .cand_vc    (cand_vc)
    );

    bind vc_port_ctrl vc_port_ctrl_chk chk0 (
        .clk       (clk),
        .reset     (reset),
        .alloc_in  (alloc_in),
        .ovc_wr    (ovc_wr),
        .credit_in (credit_in),
        .ovc_flags (ovc_flags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, run went past %0d cycles", cycle_limit);
            $display("Test FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    // random fill only where the dut must ignore the field
    function automatic noc_pkg::ivc_alloc_t decorate(input noc_pkg::ivc_alloc_t a);
        noc_pkg::ivc_alloc_t d;
        int v;
        d = a;
        for (v = 0; v < `VC_NUM; v++) begin
            if (!a.ovc_grant[v]) begin
                d.granted_ovc[v] = noc_pkg::vc_mask_t'($urandom);
            end
            if (!a.sw_grant[v]) begin
                d.tail[v] = 1'($urandom);
            end
        end
        return d;
    endfunction

    task automatic drive_stim(input port_stim_t [`PORT_NUM-1:0] s);
        int p;
        for (p = 0; p < `PORT_NUM; p++) begin
            alloc_in[p]  <= decorate(s[p].alloc);
            ovc_wr[p]    <= s[p].wr;
            credit_in[p] <= s[p].credit;
            cand_en[p]   <= s[p].cand_en;
        end
    endtask

    task automatic check_value(input string test, input int port, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error: test %s port %0d %s expected %h actual %h",
                     test, port, field, expected, actual);
            $display("Test FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_row(input string test, input port_exp_t [`PORT_NUM-1:0] e);
        int p;
        for (p = 0; p < `PORT_NUM; p++) begin
            check_value(test, p, "ivc_state", e[p].state, ivc_state[p]);
            check_value(test, p, "credit_out", e[p].credit, credit_out[p]);
            check_value(test, p, "ovc_flags", e[p].flags, ovc_flags[p]);
            check_value(test, p, "cand_vc", e[p].cand, cand_vc[p]);
        end
        assert (dut0.chk0.violations == 0) else begin
            $display("protocol checker saw an illegal input pattern during test %s", test);
            $display("Test FAILED");
            $fatal(1, "protocol violation");
        end
    endtask

    task automatic start_row();
        int p;
        st = '0;
        for (p = 0; p < `PORT_NUM; p++) begin
            ex[p].credit = '0; // credit is a one-cycle echo
        end
    endtask

    task automatic push_row(input string name);
        row_t r;
        r.stim = st;
        r.expv = ex;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic build_table();
        int i;
        ex = '0;
        ex[0].flags.empty = '1;
        ex[1].flags.empty = '1;

        start_row();
        push_row("reset_idle");

        // assignment and release on input port 0
        start_row();
        st[0].alloc.ovc_grant      = 4'b0101;
        st[0].alloc.granted_ovc[0] = 4'b0010;
        st[0].alloc.granted_ovc[2] = 4'b1000;
        ex[0].state.assigned        = 4'b0101;
        ex[0].state.assigned_ovc[0] = 4'b0010;
        ex[0].state.assigned_ovc[2] = 4'b1000;
        push_row("grant_ivc0_ivc2");

        start_row();
        st[0].alloc.sw_grant = 4'b0001;
        ex[0].credit = 4'b0001;
        push_row("sw_grant_no_tail");

        start_row();
        st[0].alloc.sw_grant = 4'b0101;
        st[0].alloc.tail     = 4'b0100;
        ex[0].credit = 4'b0101;
        ex[0].state.assigned = 4'b0001; // ovc of ivc2 stays recorded
        push_row("tail_release_ivc2");

        start_row();
        st[0].alloc.ovc_grant      = 4'b0100;
        st[0].alloc.granted_ovc[2] = 4'b0001;
        st[0].alloc.sw_grant       = 4'b0001;
        st[0].alloc.tail           = 4'b0001;
        ex[0].credit = 4'b0001;
        ex[0].state.assigned        = 4'b0100;
        ex[0].state.assigned_ovc[2] = 4'b0001;
        push_row("regrant_ivc2_release_ivc0");

        start_row();
        st[1].alloc.ovc_grant      = 4'b1000;
        st[1].alloc.granted_ovc[3] = 4'b0100;
        ex[1].state.assigned        = 4'b1000;
        ex[1].state.assigned_ovc[3] = 4'b0100;
        push_row("port1_grant_ivc3");

        start_row();
        st[1].alloc.sw_grant = 4'b1000;
        st[1].alloc.tail     = 4'b1000;
        ex[1].credit = 4'b1000;
        ex[1].state.assigned = 4'b0000;
        push_row("port1_tail_release");

        // depth walk on output port 0 vc1
        start_row();
        st[0].wr = 4'b0010;
        ex[0].flags.empty = 4'b1101;
        push_row("write_vc1_depth1");

        start_row();
        st[0].wr = 4'b0010;
        ex[0].flags.nearly_full = 4'b0010;
        push_row("write_vc1_depth2");

        start_row();
        st[0].wr     = 4'b0010;
        st[0].credit = 4'b0010;
        push_row("write_and_credit_vc1");

        start_row();
        st[0].wr = 4'b0010;
        ex[0].flags.full = 4'b0010;
        push_row("write_vc1_full");

        start_row();
        st[0].credit = 4'b0010;
        ex[0].flags.full = 4'b0000;
        push_row("credit_vc1_depth2");

        start_row();
        st[0].credit = 4'b0010;
        ex[0].flags.nearly_full = 4'b0000;
        push_row("credit_vc1_depth1");

        start_row();
        st[0].credit = 4'b0010;
        ex[0].flags.empty = 4'b1111;
        push_row("credit_vc1_empty");

        // vc0, vc1, vc2, vc3 then back to vc0
        for (i = 0; i < 5; i++) begin
            start_row();
            st[0].cand_en = 1'b1;
            ex[0].cand = 4'b0001 << (i % 4);
            push_row($sformatf("cand_rotate_%0d", i));
        end

        start_row();
        push_row("cand_hold");

        start_row();
        st[0].wr = 4'b0010;
        ex[0].flags.empty = 4'b1101;
        push_row("fill_vc1_depth1");

        start_row();
        st[0].wr = 4'b0010;
        ex[0].flags.nearly_full = 4'b0010;
        push_row("fill_vc1_depth2");

        start_row();
        st[0].cand_en = 1'b1;
        ex[0].cand = 4'b0100; // pointer sits on the nearly full vc1
        push_row("cand_skip_vc1");

        start_row();
        st[0].wr = 4'b1101;
        ex[0].flags.empty = 4'b0000;
        push_row("fill_others_depth1");

        start_row();
        st[0].wr = 4'b1101;
        ex[0].flags.nearly_full = 4'b1111;
        push_row("fill_others_depth2");

        start_row();
        st[0].cand_en = 1'b1;
        ex[0].cand = 4'b0000;
        push_row("cand_none_qualify");

        start_row();
        st[1].wr      = 4'b1000;
        st[1].cand_en = 1'b1;
        ex[1].flags.empty = 4'b0111;
        ex[1].cand = 4'b0001;
        push_row("port1_write_and_cand");
    endtask

    initial begin
        void'($urandom(32'h2d744da2));
        reset     = 1'b1;
        alloc_in  = '0;
        ovc_wr    = '0;
        credit_in = '0;
        cand_en   = '0;
        build_table();
        cycle_limit = rows.size() + 3 + 20;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        drive_stim(rows[0].stim);

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            if (i + 1 < rows.size()) begin
                drive_stim(rows[i + 1].stim);
            end else begin
                drive_stim('0);
            end
            @(negedge clk);
            check_row(names[i], rows[i].expv);
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* dv/vc_port_ctrl_chk.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

module vc_port_ctrl_chk (
    input logic                                clk,
    input logic                                reset,
    input noc_pkg::ivc_alloc_t [`PORT_NUM-1:0] alloc_in,
    input noc_pkg::vc_mask_t   [`PORT_NUM-1:0] ovc_wr,
    input noc_pkg::vc_mask_t   [`PORT_NUM-1:0] credit_in,
    input noc_pkg::ovc_flags_t [`PORT_NUM-1:0] ovc_flags
);

    int violations = 0; // read by the testbench

    for (genvar p = 0; p < `PORT_NUM; p++) begin : g_port
        for (genvar v = 0; v < `VC_NUM; v++) begin : g_vc
            // allocator hands out exactly one ovc
            a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
                alloc_in[p].ovc_grant[v] |-> $onehot(alloc_in[p].granted_ovc[v]))
                else begin
                    $error("port %0d ivc %0d granted ovc not one-hot", p, v);
                    violations++;
                end

            a_grant_vs_release: assert property (@(posedge clk) disable iff (reset)
                !(alloc_in[p].ovc_grant[v] && alloc_in[p].sw_grant[v] && alloc_in[p].tail[v]))
                else begin
                    $error("port %0d ivc %0d grant and tail release together", p, v);
                    violations++;
                end

            // no back-pressure inside, upstream must obey the flags
            a_no_write_full: assert property (@(posedge clk) disable iff (reset)
                ovc_wr[p][v] |-> !ovc_flags[p].full[v])
                else begin
                    $error("port %0d ovc %0d written while full", p, v);
                    violations++;
                end

            a_no_credit_empty: assert property (@(posedge clk) disable iff (reset)
                credit_in[p][v] |-> !ovc_flags[p].empty[v])
                else begin
                    $error("port %0d ovc %0d credit while empty", p, v);
                    violations++;
                end
        end
    end

endmodule

/* source/vc_port_ctrl.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

module vc_port_ctrl (
    input  logic                                    clk,
    input  logic                                    reset,

    // from the vc and switch allocator, one entry per input port
    input  noc_pkg::ivc_alloc_t [`PORT_NUM-1:0]     alloc_in,
    output noc_pkg::ivc_state_t [`PORT_NUM-1:0]     ivc_state,
    output noc_pkg::vc_mask_t   [`PORT_NUM-1:0]     credit_out,

    // output port side
    input  noc_pkg::vc_mask_t   [`PORT_NUM-1:0]     ovc_wr,
    input  noc_pkg::vc_mask_t   [`PORT_NUM-1:0]     credit_in,
    input  logic                [`PORT_NUM-1:0]     cand_en,
    output noc_pkg::ovc_flags_t [`PORT_NUM-1:0]     ovc_flags,
    output noc_pkg::vc_mask_t   [`PORT_NUM-1:0]     cand_vc
);

    // input ports
    for (genvar p = 0; p < `PORT_NUM; p++) begin : g_in_port
        ivc_assign_table ivc_table (
            .clk        (clk),
            .reset      (reset),
            .alloc      (alloc_in[p]),
            .state      (ivc_state[p]),
            .credit_out (credit_out[p])
        );
    end

    // output ports
    for (genvar p = 0; p < `PORT_NUM; p++) begin : g_out_port
        ovc_status ovc_stat (
            .clk        (clk),
            .reset      (reset),
            .ovc_wr     (ovc_wr[p]),
            .credit_in  (credit_in[p]),
            .cand_en    (cand_en[p]),
            .flags      (ovc_flags[p]),
            .cand_vc    (cand_vc[p])
        );
    end

endmodule

/* source/ivc_assign_table.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

module ivc_assign_table (
    input  logic                 clk,
    input  logic                 reset,
    input  noc_pkg::ivc_alloc_t  alloc,
    output noc_pkg::ivc_state_t  state,
    output noc_pkg::vc_mask_t    credit_out
);

    noc_pkg::vc_mask_t   release_vc;
    noc_pkg::ivc_state_t state_next;

    // tail leaving through the switch frees the ovc
    assign release_vc = alloc.sw_grant & alloc.tail;

    always_comb begin
        state_next = state;
        for (int v = 0; v < `VC_NUM; v++) begin
            if (release_vc[v]) begin
                // ovc number kept, only the valid bit drops
                state_next.assigned[v] = 1'b0;
            end else if (alloc.ovc_grant[v]) begin
                state_next.assigned[v]     = 1'b1;
                state_next.assigned_ovc[v] = alloc.granted_ovc[v];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= '0;
        end else begin
            state <= state_next;
        end
    end

    // one credit upstream per flit leaving the input buffer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_out <= '0;
        end else begin
            credit_out <= alloc.sw_grant;
        end
    end

endmodule

/* source/ovc_status.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

module ovc_status (
    input  logic                 clk,
    input  logic                 reset,
    input  noc_pkg::vc_mask_t    ovc_wr,
    input  noc_pkg::vc_mask_t    credit_in,
    input  logic                 cand_en,
    output noc_pkg::ovc_flags_t  flags,
    output noc_pkg::vc_mask_t    cand_vc
);

    // thresholds in counter width
    localparam noc_pkg::depth_t FULL_LVL  = noc_pkg::depth_t'(`BUF_DEPTH - 1);
    localparam noc_pkg::depth_t NFULL_LVL = noc_pkg::depth_t'(`BUF_DEPTH - 2);

    noc_pkg::depth_t [`VC_NUM-1:0] depth;

    noc_pkg::vc_mask_t request;
    noc_pkg::vc_mask_t grant;

    // one counter per output vc
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            depth <= '0;
        end else begin
            for (int v = 0; v < `VC_NUM; v++) begin
                if (ovc_wr[v] && !credit_in[v]) begin
                    depth[v] <= depth[v] + 1'b1;  // flit sent downstream
                end else if (!ovc_wr[v] && credit_in[v]) begin
                    depth[v] <= depth[v] - 1'b1;  // slot freed downstream
                end
            end
        end
    end

    // flags straight from the registered depth
    always_comb begin
        for (int v = 0; v < `VC_NUM; v++) begin
            flags.full[v]        = (depth[v] >= FULL_LVL);
            flags.nearly_full[v] = (depth[v] >= NFULL_LVL);
            flags.empty[v]       = (depth[v] == '0);
        end
    end

    // only vcs with room for at least two more flits compete
    assign request = ~flags.nearly_full;

    rr_arbiter #(
        .WIDTH   (`VC_NUM)
    ) cand_arb (
        .clk     (clk),
        .reset   (reset),
        .request (request),
        .advance (cand_en),
        .grant   (grant)
    );

    // loads zero when nothing qualifies
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cand_vc <= '0;
        end else if (cand_en) begin
            cand_vc <= grant;
        end
    end

endmodule

/* source/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] request,
    input  logic             advance,
    output logic [WIDTH-1:0] grant
);

    // priority pointer kept as a thermometer mask:
    // bits set from the pointer position up to the msb
    logic [WIDTH-1:0] prio_mask;

    logic [WIDTH-1:0] masked_req;
    logic [WIDTH-1:0] masked_grant;
    logic [WIDTH-1:0] plain_grant;
    logic [WIDTH-1:0] next_mask;

    assign masked_req = request & prio_mask;

    // isolate lowest set bit
    assign masked_grant = masked_req & (~masked_req + 1'b1);
    assign plain_grant  = request & (~request + 1'b1);

    // nothing at or after the pointer, so wrap to the bottom
    always_comb begin
        if (|masked_req) begin
            grant = masked_grant;
        end else begin
            grant = plain_grant;
        end
    end

    // everything strictly above the granted bit
    // all zero after the msb wins, which behaves as pointer at bit 0
    assign next_mask = ~(grant | (grant - 1'b1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prio_mask <= '1; // pointer at vc0
        end else if (advance && (|grant)) begin
            prio_mask <= next_mask;
        end
    end

endmodule

/* source/noc_pkg.sv */
`include "noc_defines.svh"

package noc_pkg;

    // one bit per vc
    typedef logic [`VC_NUM-1:0] vc_mask_t;

    // one one-hot output vc per input vc
    typedef vc_mask_t [`VC_NUM-1:0] ovc_sel_t;

    // occupancy count of one output vc
    typedef logic [`DEPTH_W-1:0] depth_t;

    // allocator inputs for one input port
    typedef struct packed {
        vc_mask_t ovc_grant;   // ivcs granted an ovc this cycle
        ovc_sel_t granted_ovc; // one-hot ovc per ivc
        vc_mask_t sw_grant;    // ivcs that won the switch
        vc_mask_t tail;        // head flit is a tail
    } ivc_alloc_t;

    // assignment state of one input port
    typedef struct packed {
        vc_mask_t assigned;
        ovc_sel_t assigned_ovc;
    } ivc_state_t;

    // status flags of one output port
    typedef struct packed {
        vc_mask_t full;
        vc_mask_t nearly_full;
        vc_mask_t empty;
    } ovc_flags_t;

endpackage

/* include/noc_defines.svh */
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// virtual channels per port
`define VC_NUM 4

// input and output ports handled by one controller
`define PORT_NUM 2

// flit slots per vc in the downstream buffer
`define BUF_DEPTH 4

// depth counter width, holds 0 .. BUF_DEPTH
`define DEPTH_W 3

`endif
